//--- hdl/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  cpu_pkg::alu_op_e                op,
    input  cpu_pkg::word_t                  a,
    input  cpu_pkg::word_t                  b,
    input  logic [cpu_pkg::SHAMT_WIDTH-1:0] shamt,
    output cpu_pkg::word_t                  result
);

    cpu_pkg::word_t sum;
    cpu_pkg::word_t diff;
    cpu_pkg::word_t shift_out;
    logic           lt_signed;
    logic           lt_unsigned;

    // Adder path, wraps modulo 2^32
    assign sum  = a + b;
    assign diff = a - b;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    ////////////////////////////////////////////////////////////
    // Barrel shifter, operand is b
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (op)
            cpu_pkg::ALU_SRL: shift_out = b >> shamt;
            // Sign bit fills from the left
            cpu_pkg::ALU_SRA: shift_out = $signed(b) >>> shamt;
            default:          shift_out = b << shamt;
        endcase
    end

    // Result select
    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD:  result = sum;
            cpu_pkg::ALU_SUB:  result = diff;
            cpu_pkg::ALU_AND:  result = a & b;
            cpu_pkg::ALU_OR:   result = a | b;
            cpu_pkg::ALU_XOR:  result = a ^ b;
            cpu_pkg::ALU_NOR:  result = ~(a | b);
            cpu_pkg::ALU_SLT:  result = {{(cpu_pkg::DATA_WIDTH-1){1'b0}}, lt_signed};
            cpu_pkg::ALU_SLTU: result = {{(cpu_pkg::DATA_WIDTH-1){1'b0}}, lt_unsigned};
            cpu_pkg::ALU_SLL,
            cpu_pkg::ALU_SRL,
            cpu_pkg::ALU_SRA:  result = shift_out;
            // Low half of the immediate moves up
            cpu_pkg::ALU_LUI:  result = {b[15:0], 16'b0};
            default:           result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int NUM_REGS       = 32;
    localparam int SHAMT_WIDTH    = 5;
    // Byte step between instruction words
    localparam int PC_STEP        = 4;

    typedef logic [DATA_WIDTH-1:0]     word_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    ////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////

    // Major opcodes, instr[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // SPECIAL function field, instr[5:0]
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // ALU operation, codes 12..15 unused
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_e;

    ////////////////////////////////////////////////////////////
    // Stage registers
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetch_t;

    typedef struct packed {
        logic                   valid;
        logic                   reg_w;
        reg_addr_t              rd_addr;
        reg_addr_t              rs_addr;
        reg_addr_t              rt_addr;
        alu_op_e                alu_op;
        logic                   b_is_imm;
        logic                   shamt_from_reg;
        logic [SHAMT_WIDTH-1:0] shamt;
        word_t                  imm;
        word_t                  rs_data;
        word_t                  rt_data;
    } decode_t;

    // Write-back result, also the forwarding source
    typedef struct packed {
        logic      valid;
        logic      reg_w;
        reg_addr_t rd_addr;
        word_t     data;
    } commit_t;

endpackage

`default_nettype wire

//--- hdl/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::fetch_t  fetch,
    input  cpu_pkg::commit_t wb,
    output cpu_pkg::decode_t decode
);

    logic [5:0]                      opcode;
    logic [5:0]                      funct;
    cpu_pkg::reg_addr_t              rs_addr;
    cpu_pkg::reg_addr_t              rt_addr;
    cpu_pkg::reg_addr_t              rd_addr;
    logic [cpu_pkg::SHAMT_WIDTH-1:0] shamt;
    logic [15:0]                     imm16;
    cpu_pkg::alu_op_e                alu_op;
    logic                            known;
    logic                            shamt_from_reg;
    logic                            zero_ext;
    logic                            b_is_imm;
    cpu_pkg::reg_addr_t              dest;
    cpu_pkg::word_t                  imm;
    cpu_pkg::word_t                  rs_data;
    cpu_pkg::word_t                  rt_data;
    cpu_pkg::decode_t                decode_d;

    ////////////////////////////////////////////////////////////
    // Field split
    ////////////////////////////////////////////////////////////

    assign opcode  = fetch.instr[31:26];
    assign rs_addr = fetch.instr[25:21];
    assign rt_addr = fetch.instr[20:16];
    assign rd_addr = fetch.instr[15:11];
    assign shamt   = fetch.instr[10:6];
    assign funct   = fetch.instr[5:0];
    assign imm16   = fetch.instr[15:0];

    // Opcode and funct to ALU control
    // Anything unlisted falls to ADD with no write
    always_comb begin
        known          = 1'b1;
        alu_op         = cpu_pkg::ALU_ADD;
        shamt_from_reg = 1'b0;
        zero_ext       = 1'b0;
        case (opcode)
            cpu_pkg::OP_SPECIAL: begin
                case (funct)
                    cpu_pkg::FN_SLL:  alu_op = cpu_pkg::ALU_SLL;
                    cpu_pkg::FN_SRL:  alu_op = cpu_pkg::ALU_SRL;
                    cpu_pkg::FN_SRA:  alu_op = cpu_pkg::ALU_SRA;
                    cpu_pkg::FN_SLLV: begin
                        alu_op         = cpu_pkg::ALU_SLL;
                        shamt_from_reg = 1'b1;
                    end
                    cpu_pkg::FN_SRLV: begin
                        alu_op         = cpu_pkg::ALU_SRL;
                        shamt_from_reg = 1'b1;
                    end
                    cpu_pkg::FN_SRAV: begin
                        alu_op         = cpu_pkg::ALU_SRA;
                        shamt_from_reg = 1'b1;
                    end
                    cpu_pkg::FN_ADDU: alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::FN_SUBU: alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::FN_AND:  alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::FN_OR:   alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::FN_XOR:  alu_op = cpu_pkg::ALU_XOR;
                    cpu_pkg::FN_NOR:  alu_op = cpu_pkg::ALU_NOR;
                    cpu_pkg::FN_SLT:  alu_op = cpu_pkg::ALU_SLT;
                    cpu_pkg::FN_SLTU: alu_op = cpu_pkg::ALU_SLTU;
                    default:          known  = 1'b0;
                endcase
            end
            cpu_pkg::OP_ADDIU: alu_op = cpu_pkg::ALU_ADD;
            cpu_pkg::OP_SLTI:  alu_op = cpu_pkg::ALU_SLT;
            // Sign-extended immediate, unsigned compare
            cpu_pkg::OP_SLTIU: alu_op = cpu_pkg::ALU_SLTU;
            cpu_pkg::OP_ANDI: begin
                alu_op   = cpu_pkg::ALU_AND;
                zero_ext = 1'b1;
            end
            cpu_pkg::OP_ORI: begin
                alu_op   = cpu_pkg::ALU_OR;
                zero_ext = 1'b1;
            end
            cpu_pkg::OP_XORI: begin
                alu_op   = cpu_pkg::ALU_XOR;
                zero_ext = 1'b1;
            end
            cpu_pkg::OP_LUI:   alu_op = cpu_pkg::ALU_LUI;
            default:           known  = 1'b0;
        endcase
    end

    // Every non-SPECIAL opcode is an I-type form
    assign b_is_imm = (opcode != cpu_pkg::OP_SPECIAL);
    assign dest     = b_is_imm ? rt_addr : rd_addr;

    // Logical immediates are zero-extended
    assign imm = zero_ext ? {{(cpu_pkg::DATA_WIDTH-16){1'b0}}, imm16}
                          : {{(cpu_pkg::DATA_WIDTH-16){imm16[15]}}, imm16};

    // Bypasses the word written back this cycle
    register_file u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wb      (wb),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    ////////////////////////////////////////////////////////////
    // Decode/execute register
    ////////////////////////////////////////////////////////////

    always_comb begin
        decode_d.valid          = fetch.valid;
        decode_d.reg_w          = known;
        decode_d.rd_addr        = dest;
        decode_d.rs_addr        = rs_addr;
        decode_d.rt_addr        = rt_addr;
        decode_d.alu_op         = alu_op;
        decode_d.b_is_imm       = b_is_imm;
        decode_d.shamt_from_reg = shamt_from_reg;
        decode_d.shamt          = shamt;
        decode_d.imm            = imm;
        decode_d.rs_data        = rs_data;
        decode_d.rt_data        = rt_data;
    end

    // Control bits cleared, rest is payload
    always_ff @(posedge clk) begin
        decode <= decode_d;
        if (!rst_n) begin
            decode.valid <= 1'b0;
            decode.reg_w <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::decode_t decode,
    output cpu_pkg::commit_t commit
);

    logic                            commit_writes;
    logic                            fwd_rs;
    logic                            fwd_rt;
    cpu_pkg::word_t                  op_rs;
    cpu_pkg::word_t                  op_rt;
    cpu_pkg::word_t                  alu_b;
    logic [cpu_pkg::SHAMT_WIDTH-1:0] alu_shamt;
    cpu_pkg::word_t                  alu_result;
    cpu_pkg::commit_t                commit_d;

    ////////////////////////////////////////////////////////////
    // Forwarding
    ////////////////////////////////////////////////////////////

    // Commit register holds the instruction just ahead
    // Older results already came through the regfile bypass
    assign commit_writes = commit.valid && commit.reg_w && (commit.rd_addr != '0);

    assign fwd_rs = commit_writes && (commit.rd_addr == decode.rs_addr);
    assign fwd_rt = commit_writes && (commit.rd_addr == decode.rt_addr);

    assign op_rs = fwd_rs ? commit.data : decode.rs_data;
    assign op_rt = fwd_rt ? commit.data : decode.rt_data;

    // Operand select
    // Immediate replaces rt on I-type
    assign alu_b = decode.b_is_imm ? decode.imm : op_rt;

    // Variable shifts use low bits of rs only
    assign alu_shamt = decode.shamt_from_reg ? op_rs[cpu_pkg::SHAMT_WIDTH-1:0]
                                             : decode.shamt;

    alu u_alu (
        .op     (decode.alu_op),
        .a      (op_rs),
        .b      (alu_b),
        .shamt  (alu_shamt),
        .result (alu_result)
    );

    ////////////////////////////////////////////////////////////
    // Execute/write-back register
    ////////////////////////////////////////////////////////////

    always_comb begin
        commit_d.valid   = decode.valid;
        commit_d.reg_w   = decode.reg_w;
        commit_d.rd_addr = decode.rd_addr;
        commit_d.data    = alu_result;
    end

    always_ff @(posedge clk) begin
        commit <= commit_d;
        if (!rst_n) begin
            commit.valid <= 1'b0;
            commit.reg_w <= 1'b0;
        end
    end

    // Decoder only emits defined operations
    legal_alu_op: assert property (
        @(posedge clk) disable iff (!rst_n)
        decode.valid |-> decode.alu_op inside {
            cpu_pkg::ALU_ADD, cpu_pkg::ALU_SUB, cpu_pkg::ALU_AND, cpu_pkg::ALU_OR,
            cpu_pkg::ALU_XOR, cpu_pkg::ALU_NOR, cpu_pkg::ALU_SLT, cpu_pkg::ALU_SLTU,
            cpu_pkg::ALU_SLL, cpu_pkg::ALU_SRL, cpu_pkg::ALU_SRA, cpu_pkg::ALU_LUI
        }
    );

endmodule

`default_nettype wire

//--- hdl/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
    input  logic            clk,
    input  logic            rst_n,
    output cpu_pkg::word_t  imem_addr,
    input  cpu_pkg::word_t  imem_data,
    output cpu_pkg::fetch_t fetch
);

    cpu_pkg::word_t  pc;
    cpu_pkg::fetch_t fetch_d;

    // Flow-through port, word comes back in the same cycle
    assign imem_addr = pc;

    // PC register
    // Sequential only, no redirect source left
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc + cpu_pkg::word_t'(cpu_pkg::PC_STEP);
        end
    end

    // Every cycle out of reset carries a fresh instruction
    always_comb begin
        fetch_d.valid = 1'b1;
        fetch_d.pc    = pc;
        fetch_d.instr = imem_data;
    end

    // Fetch/decode register
    // Only valid is cleared, pc and instr are payload
    always_ff @(posedge clk) begin
        fetch <= fetch_d;
        if (!rst_n) begin
            fetch.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/int_pipeline.sv
`timescale 1ns/100ps
`default_nettype none

module int_pipeline (
    input  logic             clk,
    input  logic             rst_n,
    output cpu_pkg::word_t   imem_addr,
    input  cpu_pkg::word_t   imem_data,
    output cpu_pkg::commit_t commit
);

    // Stage registers
    cpu_pkg::fetch_t  fetch;
    cpu_pkg::decode_t decode;

    ////////////////////////////////////////////////////////////
    // IF
    ////////////////////////////////////////////////////////////

    fetch_stage u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .fetch     (fetch)
    );

    // ID, register file written from commit
    decode_stage u_decode (
        .clk    (clk),
        .rst_n  (rst_n),
        .fetch  (fetch),
        .wb     (commit),
        .decode (decode)
    );

    // EX, its register is the write-back stage
    execute_stage u_execute (
        .clk    (clk),
        .rst_n  (rst_n),
        .decode (decode),
        .commit (commit)
    );

endmodule

`default_nettype wire

//--- hdl/register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::reg_addr_t rs_addr,
    input  cpu_pkg::reg_addr_t rt_addr,
    input  cpu_pkg::commit_t   wb,
    output cpu_pkg::word_t     rs_data,
    output cpu_pkg::word_t     rt_data
);

    cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];
    logic           wr_en;

    // Writes to $0 are dropped here
    assign wr_en = wb.valid && wb.reg_w && (wb.rd_addr != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd_addr] <= wb.data;
        end
    end

    // One read port
    // $0 first, then the word being written this cycle
    function automatic cpu_pkg::word_t read_port(input cpu_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en && (wb.rd_addr == addr)) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

    // Execute must never hand over a write with an undriven destination
    wr_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wb.valid && wb.reg_w) |-> !$isunknown(wb.rd_addr)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the int_pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/100ps --top-module int_pipeline_tb \
    -f verilog.f -o int_pipeline_sim \
    && ./obj_dir/int_pipeline_sim \
    || { echo "simulation did not pass"; exit 1; }

//--- tb/int_pipeline_tb.sv
`timescale 1ns/100ps
`default_nettype none

module int_pipeline_tb;

    localparam int CLK_HALF     = 4;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 4;
    // Fetch, decode and execute registers
    localparam int PIPE_DEPTH   = 3;
    localparam int MAX_ENTRIES  = 64;
    localparam int RANDOM_SEED  = 86288;

    logic             clk;
    logic             rst_n;
    cpu_pkg::word_t   imem_addr;
    cpu_pkg::word_t   imem_data;
    cpu_pkg::commit_t commit;

    // Program table, one row per instruction word
    string            test_name       [MAX_ENTRIES];
    cpu_pkg::word_t   instr_mem       [MAX_ENTRIES];
    cpu_pkg::commit_t expected_commit [MAX_ENTRIES];
    int               num_entries;
    // Architectural register state of the reference model
    cpu_pkg::word_t   model_regs      [cpu_pkg::NUM_REGS];
    int               cycle_count;

    int_pipeline u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .commit    (commit)
    );

    ////////////////////////////////////////////////////////////
    // Failure and compare
    ////////////////////////////////////////////////////////////

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    // Address and data only matter when the commit writes
    task automatic check_commit(input string name, input cpu_pkg::commit_t expected,
                                input cpu_pkg::commit_t actual);
        logic mismatch;
        mismatch = (actual.reg_w !== expected.reg_w);
        if (expected.reg_w) begin
            mismatch = mismatch || (actual.rd_addr !== expected.rd_addr)
                                || (actual.data !== expected.data);
        end
        if (mismatch) begin
            stop_on_failure($sformatf(
                "Error: %s expected reg_w=%0b rd=%0d data=%h, actual reg_w=%0b rd=%0d data=%h",
                name, expected.reg_w, expected.rd_addr, expected.data,
                actual.reg_w, actual.rd_addr, actual.data));
        end
    endtask

    task automatic check_fetch_addr(input string name, input cpu_pkg::word_t expected,
                                    input cpu_pkg::word_t actual);
        if (actual !== expected) begin
            stop_on_failure($sformatf("Error: %s expected %h, actual %h",
                                      name, expected, actual));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // ISA reference model and table builders
    ////////////////////////////////////////////////////////////

    function automatic cpu_pkg::word_t arith_shift_right(
        input cpu_pkg::word_t                  value,
        input logic [cpu_pkg::SHAMT_WIDTH-1:0] amount
    );
        cpu_pkg::word_t fill;
        // Vacated upper bits copy the sign
        fill = value[cpu_pkg::DATA_WIDTH-1] ? ~({cpu_pkg::DATA_WIDTH{1'b1}} >> amount) : '0;
        return (value >> amount) | fill;
    endfunction

    task automatic append_entry(input string name, input cpu_pkg::word_t instr,
                                input logic reg_w, input cpu_pkg::reg_addr_t rd,
                                input cpu_pkg::word_t data);
        cpu_pkg::commit_t entry;
        if (num_entries >= MAX_ENTRIES) begin
            stop_on_failure("program table is full");
        end else begin
            entry.valid   = 1'b1;
            entry.reg_w   = reg_w;
            entry.rd_addr = rd;
            entry.data    = data;
            test_name[num_entries]       = name;
            instr_mem[num_entries]       = instr;
            expected_commit[num_entries] = entry;
            num_entries++;
            // $0 keeps its zero
            if (reg_w && (rd != '0)) begin
                model_regs[rd] = data;
            end
        end
    endtask

    task automatic add_itype(input string name, input logic [5:0] op,
                             input cpu_pkg::reg_addr_t rt, input cpu_pkg::reg_addr_t rs,
                             input logic [15:0] imm16);
        cpu_pkg::word_t sext;
        cpu_pkg::word_t zext;
        cpu_pkg::word_t a;
        cpu_pkg::word_t res;
        sext = {{16{imm16[15]}}, imm16};
        zext = {16'h0000, imm16};
        a    = model_regs[rs];
        case (op)
            cpu_pkg::OP_ADDIU: res = a + sext;
            cpu_pkg::OP_SLTI:  res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            // Unsigned compare against the sign-extended value
            cpu_pkg::OP_SLTIU: res = (a < sext) ? 32'd1 : 32'd0;
            cpu_pkg::OP_ANDI:  res = a & zext;
            cpu_pkg::OP_ORI:   res = a | zext;
            cpu_pkg::OP_XORI:  res = a ^ zext;
            cpu_pkg::OP_LUI:   res = {imm16, 16'h0000};
            default:           res = '0;
        endcase
        append_entry(name, {op, rs, rt, imm16}, 1'b1, rt, res);
    endtask

    task automatic add_rtype(input string name, input logic [5:0] fn,
                             input cpu_pkg::reg_addr_t rd, input cpu_pkg::reg_addr_t rs,
                             input cpu_pkg::reg_addr_t rt,
                             input logic [cpu_pkg::SHAMT_WIDTH-1:0] sa);
        cpu_pkg::word_t                  a;
        cpu_pkg::word_t                  b;
        cpu_pkg::word_t                  res;
        logic [cpu_pkg::SHAMT_WIDTH-1:0] amt;
        a = model_regs[rs];
        b = model_regs[rt];
        // Variable shifts take the low bits of rs
        if ((fn == cpu_pkg::FN_SLLV) || (fn == cpu_pkg::FN_SRLV) || (fn == cpu_pkg::FN_SRAV)) begin
            amt = a[cpu_pkg::SHAMT_WIDTH-1:0];
        end else begin
            amt = sa;
        end
        case (fn)
            cpu_pkg::FN_SLL, cpu_pkg::FN_SLLV: res = b << amt;
            cpu_pkg::FN_SRL, cpu_pkg::FN_SRLV: res = b >> amt;
            cpu_pkg::FN_SRA, cpu_pkg::FN_SRAV: res = arith_shift_right(b, amt);
            cpu_pkg::FN_ADDU: res = a + b;
            cpu_pkg::FN_SUBU: res = a - b;
            cpu_pkg::FN_AND:  res = a & b;
            cpu_pkg::FN_OR:   res = a | b;
            cpu_pkg::FN_XOR:  res = a ^ b;
            cpu_pkg::FN_NOR:  res = ~(a | b);
            cpu_pkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            cpu_pkg::FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            default:          res = '0;
        endcase
        append_entry(name, {cpu_pkg::OP_SPECIAL, rs, rt, rd, sa, fn}, 1'b1, rd, res);
    endtask

    // Dropped encoding, commits without a write
    task automatic add_unknown(input string name, input cpu_pkg::word_t instr);
        append_entry(name, instr, 1'b0, '0, '0);
    endtask

    // LUI then ORI into the same register
    task automatic load_word(input string name, input cpu_pkg::reg_addr_t rt,
                             input cpu_pkg::word_t value);
        add_itype({name, "_hi"}, cpu_pkg::OP_LUI, rt, 5'd0, value[31:16]);
        add_itype({name, "_lo"}, cpu_pkg::OP_ORI, rt, rt, value[15:0]);
    endtask

    task automatic build_program();
        cpu_pkg::word_t val;
        num_entries = 0;
        for (int r = 0; r < cpu_pkg::NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        // Immediates and their extension
        add_itype("addiu_pos", cpu_pkg::OP_ADDIU, 5'd1, 5'd0, 16'h7fff);
        add_itype("addiu_neg", cpu_pkg::OP_ADDIU, 5'd2, 5'd0, 16'h8000);
        add_itype("ori_zext", cpu_pkg::OP_ORI, 5'd3, 5'd0, 16'h8001);
        add_itype("lui", cpu_pkg::OP_LUI, 5'd4, 5'd0, 16'ha5c3);
        add_itype("ori_after_lui", cpu_pkg::OP_ORI, 5'd4, 5'd4, 16'h1234);
        add_itype("andi_zext", cpu_pkg::OP_ANDI, 5'd5, 5'd2, 16'hf0f0);
        add_itype("xori_zext", cpu_pkg::OP_XORI, 5'd6, 5'd2, 16'hffff);
        add_itype("slti_neg", cpu_pkg::OP_SLTI, 5'd7, 5'd2, 16'h0001);
        add_itype("sltiu_neg", cpu_pkg::OP_SLTIU, 5'd8, 5'd2, 16'h0001);
        // Arithmetic and logic on random operands
        load_word("load_a", 5'd10, $urandom());
        load_word("load_b", 5'd11, $urandom());
        add_rtype("addu", cpu_pkg::FN_ADDU, 5'd12, 5'd10, 5'd11, 5'd0);
        add_rtype("subu", cpu_pkg::FN_SUBU, 5'd13, 5'd10, 5'd11, 5'd0);
        add_rtype("and", cpu_pkg::FN_AND, 5'd14, 5'd10, 5'd11, 5'd0);
        add_rtype("or", cpu_pkg::FN_OR, 5'd15, 5'd10, 5'd11, 5'd0);
        add_rtype("xor", cpu_pkg::FN_XOR, 5'd16, 5'd10, 5'd11, 5'd0);
        add_rtype("nor", cpu_pkg::FN_NOR, 5'd17, 5'd10, 5'd11, 5'd0);
        // Same magnitude, opposite sign
        val = $urandom();
        load_word("load_pos", 5'd18, val & 32'h7fff_ffff);
        load_word("load_neg", 5'd19, val | 32'h8000_0000);
        add_rtype("slt_neg_pos", cpu_pkg::FN_SLT, 5'd20, 5'd19, 5'd18, 5'd0);
        add_rtype("sltu_neg_pos", cpu_pkg::FN_SLTU, 5'd21, 5'd19, 5'd18, 5'd0);
        add_rtype("slt_pos_neg", cpu_pkg::FN_SLT, 5'd22, 5'd18, 5'd19, 5'd0);
        add_rtype("sltu_pos_neg", cpu_pkg::FN_SLTU, 5'd23, 5'd18, 5'd19, 5'd0);
        // Shifts, constant amounts then register amounts
        load_word("load_shift", 5'd24, $urandom() | 32'h8000_0000);
        add_rtype("sll_7", cpu_pkg::FN_SLL, 5'd25, 5'd0, 5'd24, 5'd7);
        add_rtype("srl_13", cpu_pkg::FN_SRL, 5'd26, 5'd0, 5'd24, 5'd13);
        add_rtype("sra_13", cpu_pkg::FN_SRA, 5'd27, 5'd0, 5'd24, 5'd13);
        // Upper bits of the amount must be ignored
        load_word("load_amt_9", 5'd28, ($urandom() & 32'hffff_ffe0) | 32'd9);
        add_rtype("sllv_9", cpu_pkg::FN_SLLV, 5'd29, 5'd28, 5'd24, 5'd0);
        add_rtype("srlv_9", cpu_pkg::FN_SRLV, 5'd30, 5'd28, 5'd24, 5'd0);
        add_rtype("srav_9", cpu_pkg::FN_SRAV, 5'd31, 5'd28, 5'd24, 5'd0);
        load_word("load_amt_31", 5'd28, $urandom() | 32'h0000_001f);
        add_rtype("srav_31", cpu_pkg::FN_SRAV, 5'd25, 5'd28, 5'd24, 5'd0);
        // Back-to-back dependencies
        add_itype("fwd_seed", cpu_pkg::OP_ADDIU, 5'd1, 5'd0, 16'h0005);
        add_rtype("fwd_dist1", cpu_pkg::FN_ADDU, 5'd2, 5'd1, 5'd1, 5'd0);
        add_rtype("fwd_dist1_dist2", cpu_pkg::FN_SUBU, 5'd3, 5'd2, 5'd1, 5'd0);
        add_rtype("fwd_xor", cpu_pkg::FN_XOR, 5'd4, 5'd3, 5'd2, 5'd0);
        add_itype("fwd_self", cpu_pkg::OP_ADDIU, 5'd3, 5'd3, 16'h0001);
        // Amount 35 wraps to 3
        add_itype("fwd_amt", cpu_pkg::OP_ADDIU, 5'd5, 5'd0, 16'h0023);
        add_rtype("fwd_sllv", cpu_pkg::FN_SLLV, 5'd6, 5'd5, 5'd2, 5'd0);
        // Writes to $0 and dropped encodings
        add_itype("write_zero", cpu_pkg::OP_ADDIU, 5'd0, 5'd0, 16'h1234);
        add_rtype("read_zero_dist1", cpu_pkg::FN_ADDU, 5'd5, 5'd0, 5'd0, 5'd0);
        add_rtype("read_zero_dist2", cpu_pkg::FN_OR, 5'd6, 5'd0, 5'd0, 5'd0);
        add_itype("set_r7", cpu_pkg::OP_ADDIU, 5'd7, 5'd0, 16'h0055);
        add_unknown("unknown_lw", {6'h23, 5'd0, 5'd7, 16'h0010});
        add_unknown("unknown_movz", {cpu_pkg::OP_SPECIAL, 5'd1, 5'd0, 5'd7, 5'd0, 6'h0a});
        add_rtype("r7_unchanged", cpu_pkg::FN_ADDU, 5'd8, 5'd7, 5'd0, 5'd0);
    endtask

    ////////////////////////////////////////////////////////////
    // Clock, instruction memory, monitors
    ////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Answers the address the PC shows after each edge
    initial begin
        int             idx;
        logic           held_in_reset;
        cpu_pkg::word_t expected_addr;
        imem_data     = '0;
        expected_addr = '0;
        forever begin
            @(posedge clk);
            // Reset level the PC register saw at this edge
            held_in_reset = !rst_n;
            #DRIVE_DELAY;
            if (held_in_reset) begin
                expected_addr = '0;
            end else begin
                expected_addr = expected_addr + cpu_pkg::word_t'(cpu_pkg::PC_STEP);
            end
            check_fetch_addr("fetch_addr", expected_addr, imem_addr);
            idx = int'(imem_addr / cpu_pkg::PC_STEP);
            // Past the table the word is SLL $0, $0, 0
            if (idx < num_entries) begin
                imem_data = instr_mem[idx];
            end else begin
                imem_data = '0;
            end
        end
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count > RESET_CYCLES + num_entries + 20) begin
                stop_on_failure($sformatf("run timed out after %0d cycles", cycle_count));
            end
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (!rst_n && (commit.valid === 1'b1)) begin
                stop_on_failure("a commit was valid while reset was held");
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Reset and run loop
    ////////////////////////////////////////////////////////////

    initial begin
        int wait_cycles;
        rst_n = 1'b0;
        void'($urandom(RANDOM_SEED));
        build_program();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        // Word at address 0 reaches commit after the three stage registers
        wait_cycles = 0;
        @(negedge clk);
        while (commit.valid !== 1'b1) begin
            if (wait_cycles >= PIPE_DEPTH) begin
                stop_on_failure("no commit arrived after reset within the pipeline depth");
            end
            wait_cycles++;
            @(negedge clk);
        end
        // One commit per cycle in table order
        for (int i = 0; i < num_entries; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            if (commit.valid !== 1'b1) begin
                stop_on_failure($sformatf("commit for %s did not arrive on its cycle",
                                          test_name[i]));
            end
            check_commit(test_name[i], expected_commit[i], commit);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
hdl/cpu_pkg.sv
hdl/alu.sv
hdl/register_file.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/int_pipeline.sv
tb/int_pipeline_tb.sv
